/* verilog/axil_mem_pkg.sv */
// AXI-Lite response codes and default bus widths and memory depth for the data RAM

package axil_mem_pkg;

  // ------------------------------
  // Response codes
  // ------------------------------

  // Two-bit AXI response of which only OKAY and SLVERR are produced
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // ------------------------------
  // Default geometry
  // ------------------------------

  // One 64-bit word per beat
  localparam int DEF_DATA_WIDTH = 64;

  // Byte address width
  localparam int DEF_ADDR_WIDTH = 32;

  // Number of words as a power of two
  localparam int DEF_MEM_DEPTH = 256;

endpackage

/* verilog/strobe_sram.sv */
// Simple dual-port SRAM with byte-strobed write port and registered read port
`timescale 1ns/1ps

module strobe_sram #(
  parameter int DATA_WIDTH = axil_mem_pkg::DEF_DATA_WIDTH,
  parameter int MEM_DEPTH  = axil_mem_pkg::DEF_MEM_DEPTH,
  localparam int STRB_WIDTH = DATA_WIDTH / 8,
  localparam int IDX_WIDTH  = $clog2(MEM_DEPTH)
) (
  input  logic                  i_aclk,

  // Write port
  input  logic                  i_wr_en,
  input  logic [IDX_WIDTH-1:0]  i_wr_idx,
  input  logic [DATA_WIDTH-1:0] i_wr_data,
  input  logic [STRB_WIDTH-1:0] i_wr_strb,

  // Read port
  input  logic                  i_rd_en,
  input  logic [IDX_WIDTH-1:0]  i_rd_idx,
  output logic [DATA_WIDTH-1:0] o_rd_data
);

  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

  // ------------------------------
  // Write port
  // ------------------------------
  // Only lanes with their strobe bit set are touched
  always_ff @(posedge i_aclk) begin
    if (i_wr_en) begin
      for (int lane = 0; lane < STRB_WIDTH; lane++) begin
        if (i_wr_strb[lane]) begin
          mem[i_wr_idx][lane*8 +: 8] <= i_wr_data[lane*8 +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Read port
  // ------------------------------
  // Old data on a same-word collision
  always_ff @(posedge i_aclk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_idx];
    end
  end

  // Controllers must hand over a known, in-range index
  a_wr_idx_ok: assert property (
    @(posedge i_aclk)
    i_wr_en |-> !$isunknown(i_wr_idx) && (i_wr_idx < MEM_DEPTH)
  );

  a_rd_idx_ok: assert property (
    @(posedge i_aclk)
    i_rd_en |-> !$isunknown(i_rd_idx) && (i_rd_idx < MEM_DEPTH)
  );

endmodule

/* verilog/axil_wr_ctrl.sv */
// AXI-Lite write channel FSM with address capture, range check and response generation
`timescale 1ns/1ps

module axil_wr_ctrl #(
  parameter int DATA_WIDTH = axil_mem_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH = axil_mem_pkg::DEF_ADDR_WIDTH,
  parameter int MEM_DEPTH  = axil_mem_pkg::DEF_MEM_DEPTH,
  localparam int STRB_WIDTH = DATA_WIDTH / 8,
  localparam int IDX_WIDTH  = $clog2(MEM_DEPTH)
) (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,

  // Write address channel
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  logic [ADDR_WIDTH-1:0]   i_awaddr,

  // Write data channel
  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  logic [DATA_WIDTH-1:0]   i_wdata,
  input  logic [STRB_WIDTH-1:0]   i_wstrb,

  // Write response channel
  output logic                    o_bvalid,
  input  logic                    i_bready,
  output axil_mem_pkg::axil_resp_e o_bresp,

  // SRAM write port
  output logic                    o_wr_en,
  output logic [IDX_WIDTH-1:0]    o_wr_idx,
  output logic [DATA_WIDTH-1:0]   o_wr_data,
  output logic [STRB_WIDTH-1:0]   o_wr_strb
);
  import axil_mem_pkg::*;

  // Byte offset bits inside one word
  localparam int OFFS_WIDTH = $clog2(STRB_WIDTH);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e                        state_q;
  logic                             in_range_q;
  logic [IDX_WIDTH-1:0]             idx_q;
  logic [ADDR_WIDTH-OFFS_WIDTH-1:0] aw_word;
  logic                             aw_in_range;
  logic                             aw_fire;
  logic                             w_fire;
  logic                             b_fire;

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;

  // Full word index is range checked before truncation
  assign aw_word     = i_awaddr[ADDR_WIDTH-1:OFFS_WIDTH];
  assign aw_in_range = (aw_word < MEM_DEPTH);

  // ------------------------------
  // State machine
  // ------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q    <= WR_IDLE;
      in_range_q <= 1'b0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (aw_fire) begin
            state_q    <= WR_DATA;
            in_range_q <= aw_in_range;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            state_q <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (b_fire) begin
            state_q <= WR_IDLE;
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      idx_q <= aw_word[IDX_WIDTH-1:0];
    end
  end

  assign o_awready = (state_q == WR_IDLE);
  assign o_wready  = (state_q == WR_DATA);
  assign o_bvalid  = (state_q == WR_RESP);

  always_comb begin
    if (in_range_q) begin
      o_bresp = RESP_OKAY;
    end else begin
      o_bresp = RESP_SLVERR;
    end
  end

  // ------------------------------
  // SRAM write on the W beat edge
  // ------------------------------
  // An empty strobe needs no SRAM cycle
  assign o_wr_en   = w_fire & in_range_q & (|i_wstrb);
  assign o_wr_idx  = idx_q;
  assign o_wr_data = i_wdata;
  assign o_wr_strb = i_wstrb;

  // Response held with its code until the master takes it
  a_bresp_hold: assert property (
    @(posedge i_aclk) disable iff (!i_rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp)
  );

endmodule

/* verilog/axil_rd_ctrl.sv */
// AXI-Lite read channel FSM with range check, SRAM read issue and read-data hold
`timescale 1ns/1ps

module axil_rd_ctrl #(
  parameter int DATA_WIDTH = axil_mem_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH = axil_mem_pkg::DEF_ADDR_WIDTH,
  parameter int MEM_DEPTH  = axil_mem_pkg::DEF_MEM_DEPTH,
  localparam int STRB_WIDTH = DATA_WIDTH / 8,
  localparam int IDX_WIDTH  = $clog2(MEM_DEPTH)
) (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,

  // Read address channel
  input  logic                    i_arvalid,
  output logic                    o_arready,
  input  logic [ADDR_WIDTH-1:0]   i_araddr,

  // Read data channel
  output logic                    o_rvalid,
  input  logic                    i_rready,
  output logic [DATA_WIDTH-1:0]   o_rdata,
  output axil_mem_pkg::axil_resp_e o_rresp,

  // SRAM read port
  output logic                    o_rd_en,
  output logic [IDX_WIDTH-1:0]    o_rd_idx,
  input  logic [DATA_WIDTH-1:0]   i_rd_data
);
  import axil_mem_pkg::*;

  localparam int OFFS_WIDTH = $clog2(STRB_WIDTH);

  typedef enum logic {
    RD_IDLE,
    RD_WAIT
  } rd_state_e;

  rd_state_e                        state_q;
  logic                             in_range_q;
  logic [ADDR_WIDTH-OFFS_WIDTH-1:0] ar_word;
  logic                             ar_fire;
  logic                             r_fire;

  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  assign ar_word = i_araddr[ADDR_WIDTH-1:OFFS_WIDTH];

  // ------------------------------
  // State machine
  // ------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q    <= RD_IDLE;
      in_range_q <= 1'b0;
    end else if (state_q == RD_IDLE) begin
      if (ar_fire) begin
        state_q    <= RD_WAIT;
        in_range_q <= (ar_word < MEM_DEPTH);
      end
    end else if (r_fire) begin
      state_q <= RD_IDLE;
    end
  end

  assign o_arready = (state_q == RD_IDLE);
  assign o_rvalid  = (state_q == RD_WAIT);

  // SRAM answers one edge after the AR beat
  assign o_rd_en  = ar_fire;
  assign o_rd_idx = ar_word[IDX_WIDTH-1:0];

  // Out-of-range reads return zero data
  always_comb begin
    if (in_range_q) begin
      o_rdata = i_rd_data;
      o_rresp = RESP_OKAY;
    end else begin
      o_rdata = '0;
      o_rresp = RESP_SLVERR;
    end
  end

  // One read outstanding at a time
  a_one_outstanding: assert property (
    @(posedge i_aclk) disable iff (!i_rst_n)
    !(o_arready && o_rvalid)
  );

  // SRAM output must hold while the master stalls
  a_rdata_hold: assert property (
    @(posedge i_aclk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp)
  );

endmodule

/* verilog/axil_data_sram.sv */
// AXI-Lite data RAM top level joining the write and read controllers to the SRAM
`timescale 1ns/1ps

module axil_data_sram #(
  parameter int DATA_WIDTH = axil_mem_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH = axil_mem_pkg::DEF_ADDR_WIDTH,
  parameter int MEM_DEPTH  = axil_mem_pkg::DEF_MEM_DEPTH,
  localparam int STRB_WIDTH = DATA_WIDTH / 8,
  localparam int IDX_WIDTH  = $clog2(MEM_DEPTH)
) (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,

  // Write address channel
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  logic [ADDR_WIDTH-1:0]   i_awaddr,

  // Write data channel
  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  logic [DATA_WIDTH-1:0]   i_wdata,
  input  logic [STRB_WIDTH-1:0]   i_wstrb,

  // Write response channel
  output logic                    o_bvalid,
  input  logic                    i_bready,
  output axil_mem_pkg::axil_resp_e o_bresp,

  // Read address channel
  input  logic                    i_arvalid,
  output logic                    o_arready,
  input  logic [ADDR_WIDTH-1:0]   i_araddr,

  // Read data channel
  output logic                    o_rvalid,
  input  logic                    i_rready,
  output logic [DATA_WIDTH-1:0]   o_rdata,
  output axil_mem_pkg::axil_resp_e o_rresp
);

  // ------------------------------
  // Controller to SRAM wiring
  // ------------------------------
  logic                  wr_en;
  logic [IDX_WIDTH-1:0]  wr_idx;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [STRB_WIDTH-1:0] wr_strb;
  logic                  rd_en;
  logic [IDX_WIDTH-1:0]  rd_idx;
  logic [DATA_WIDTH-1:0] rd_data;

  axil_wr_ctrl #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_wr_ctrl (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .o_wr_en   (wr_en),
    .o_wr_idx  (wr_idx),
    .o_wr_data (wr_data),
    .o_wr_strb (wr_strb)
  );

  axil_rd_ctrl #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_rd_ctrl (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_rd_en   (rd_en),
    .o_rd_idx  (rd_idx),
    .i_rd_data (rd_data)
  );

  // Storage shared by both channels
  strobe_sram #(
    .DATA_WIDTH (DATA_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_sram (
    .i_aclk    (i_aclk),
    .i_wr_en   (wr_en),
    .i_wr_idx  (wr_idx),
    .i_wr_data (wr_data),
    .i_wr_strb (wr_strb),
    .i_rd_en   (rd_en),
    .i_rd_idx  (rd_idx),
    .o_rd_data (rd_data)
  );

endmodule

/* tb/tb_axil_data_sram.sv */
// Testbench for the AXI-Lite data RAM with random master traffic, reference model and checks
`timescale 1ns/1ps

module tb_axil_data_sram;

  localparam int DATA_WIDTH = 64;
  localparam int ADDR_WIDTH = 32;
  localparam int MEM_DEPTH  = 64;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int TIMEOUT    = 200;
  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  logic i_aclk, i_rst_n;
  logic i_awvalid, o_awready, i_wvalid, o_wready, o_bvalid, i_bready;
  logic i_arvalid, o_arready, o_rvalid, i_rready;
  logic [ADDR_WIDTH-1:0] i_awaddr, i_araddr;
  logic [DATA_WIDTH-1:0] i_wdata, o_rdata;
  logic [STRB_WIDTH-1:0] i_wstrb;
  logic [1:0]            o_bresp, o_rresp;

  // Reference memory with a written mask per byte lane
  logic [DATA_WIDTH-1:0] model_mem [MEM_DEPTH];
  logic [STRB_WIDTH-1:0] written   [MEM_DEPTH];
  logic [31:0]           rng_state;
  int                    errors;
  int                    checks;

  axil_data_sram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) UUT (
    .i_aclk (i_aclk), .i_rst_n (i_rst_n),
    .i_awvalid (i_awvalid), .o_awready (o_awready), .i_awaddr (i_awaddr),
    .i_wvalid (i_wvalid), .o_wready (o_wready), .i_wdata (i_wdata), .i_wstrb (i_wstrb),
    .o_bvalid (o_bvalid), .i_bready (i_bready), .o_bresp (o_bresp),
    .i_arvalid (i_arvalid), .o_arready (o_arready), .i_araddr (i_araddr),
    .o_rvalid (o_rvalid), .i_rready (i_rready), .o_rdata (o_rdata), .o_rresp (o_rresp)
  );

  initial begin
    i_aclk = 1'b0;
    forever #2 i_aclk = ~i_aclk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] byte_mask(input logic [STRB_WIDTH-1:0] strb);
    logic [DATA_WIDTH-1:0] m;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      m[i*8 +: 8] = {8{strb[i]}};
    end
    return m;
  endfunction

  // Word-aligned address where one in oor_one_in lands beyond the memory
  function automatic logic [ADDR_WIDTH-1:0] rand_addr(input int lo, input int span,
                                                      input int oor_one_in);
    logic [31:0] word;
    if (oor_one_in > 0 && next_rand() % oor_one_in == 0) begin
      word = MEM_DEPTH + (next_rand() >> 8);
    end else begin
      word = lo + next_rand() % span;
    end
    return word * STRB_WIDTH;
  endfunction

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation failed");
    $finish;
  endtask

  // ------------------------------
  // Master transactions
  // ------------------------------
  task automatic write_txn(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
                           input logic [STRB_WIDTH-1:0] strb, input int stall);
    int          cnt;
    logic [31:0] word;
    logic [1:0]  resp;
    word = addr / STRB_WIDTH;
    i_awvalid = 1'b1;
    i_awaddr  = addr;
    cnt = 0;
    while (!o_awready) begin
      @(negedge i_aclk);
      cnt++;
      if (cnt > TIMEOUT) report_timeout("o_awready");
    end
    @(negedge i_aclk);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b1;
    i_wdata   = data;
    i_wstrb   = strb;
    cnt = 0;
    while (!o_wready) begin
      @(negedge i_aclk);
      cnt++;
      if (cnt > TIMEOUT) report_timeout("o_wready");
    end
    @(negedge i_aclk);
    i_wvalid = 1'b0;
    if (word < MEM_DEPTH) begin
      model_mem[word] = (model_mem[word] & ~byte_mask(strb)) | (data & byte_mask(strb));
      written[word]   = written[word] | strb;
    end
    cnt = 0;
    while (!o_bvalid) begin
      @(negedge i_aclk);
      cnt++;
      if (cnt > TIMEOUT) report_timeout("o_bvalid");
    end
    resp = o_bresp;
    check_value("o_bresp", resp, (word < MEM_DEPTH) ? OKAY : SLVERR);
    // Response held and AW channel closed while the master stalls
    repeat (stall) begin
      @(negedge i_aclk);
      check_value("o_bvalid", o_bvalid, 1'b1);
      check_value("o_bresp", o_bresp, resp);
      check_value("o_awready", o_awready, 1'b0);
    end
    i_bready = 1'b1;
    @(negedge i_aclk);
    i_bready = 1'b0;
    check_value("o_bvalid", o_bvalid, 1'b0);
  endtask

  task automatic read_txn(input logic [ADDR_WIDTH-1:0] addr, input int stall);
    int                    cnt;
    logic [31:0]           word;
    logic [DATA_WIDTH-1:0] data;
    logic [DATA_WIDTH-1:0] mask;
    logic [1:0]            resp;
    word = addr / STRB_WIDTH;
    i_arvalid = 1'b1;
    i_araddr  = addr;
    cnt = 0;
    while (!o_arready) begin
      @(negedge i_aclk);
      cnt++;
      if (cnt > TIMEOUT) report_timeout("o_arready");
    end
    @(negedge i_aclk);
    i_arvalid = 1'b0;
    cnt = 0;
    while (!o_rvalid) begin
      @(negedge i_aclk);
      cnt++;
      if (cnt > TIMEOUT) report_timeout("o_rvalid");
    end
    data = o_rdata;
    resp = o_rresp;
    if (word < MEM_DEPTH) begin
      // Lanes never written are skipped
      mask = byte_mask(written[word]);
      check_value("o_rresp", resp, OKAY);
      check_value("o_rdata", data & mask, model_mem[word] & mask);
    end else begin
      check_value("o_rresp", resp, SLVERR);
      check_value("o_rdata", data, '0);
    end
    repeat (stall) begin
      @(negedge i_aclk);
      check_value("o_rvalid", o_rvalid, 1'b1);
      check_value("o_rdata", o_rdata, data);
      check_value("o_rresp", o_rresp, resp);
      check_value("o_arready", o_arready, 1'b0);
    end
    i_rready = 1'b1;
    @(negedge i_aclk);
    i_rready = 1'b0;
    check_value("o_rvalid", o_rvalid, 1'b0);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [ADDR_WIDTH-1:0] addr;
    rng_state = 32'd44;
    errors = 0;
    checks = 0;
    i_rst_n = 1'b0;
    {i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready} = '0;
    i_awaddr = '0;
    i_araddr = '0;
    i_wdata  = '0;
    i_wstrb  = '0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      written[i]   = '0;
      model_mem[i] = '0;
    end
    repeat (16) @(posedge i_aclk);
    @(negedge i_aclk);
    i_rst_n = 1'b1;
    @(negedge i_aclk);
    check_value("o_awready", o_awready, 1'b1);
    check_value("o_arready", o_arready, 1'b1);
    check_value("o_wready", o_wready, 1'b0);
    check_value("o_bvalid", o_bvalid, 1'b0);
    check_value("o_rvalid", o_rvalid, 1'b0);

    // Full-strobe fill of every word and read back
    for (int i = 0; i < MEM_DEPTH; i++) begin
      write_txn(i * STRB_WIDTH, {next_rand(), next_rand()}, '1, 0);
    end
    for (int i = 0; i < MEM_DEPTH; i++) begin
      read_txn(i * STRB_WIDTH, 0);
    end

    // Partial strobes
    for (int i = 0; i < 100; i++) begin
      addr = rand_addr(0, MEM_DEPTH, 0);
      write_txn(addr, {next_rand(), next_rand()}, STRB_WIDTH'(next_rand()), 0);
      read_txn(addr, 0);
    end

    // Out-of-range accesses leave the aliased in-range word untouched
    for (int i = 0; i < 20; i++) begin
      addr = rand_addr(0, MEM_DEPTH, 1);
      write_txn(addr, {next_rand(), next_rand()}, '1, 0);
      read_txn(addr, 0);
      read_txn(((addr / STRB_WIDTH) % MEM_DEPTH) * STRB_WIDTH, 0);
    end

    // Random stalls on both response channels
    for (int i = 0; i < 40; i++) begin
      addr = rand_addr(0, MEM_DEPTH, 8);
      write_txn(addr, {next_rand(), next_rand()}, STRB_WIDTH'(next_rand()), next_rand() % 8);
      read_txn(addr, next_rand() % 8);
    end

    // Writes to the lower half race reads of the upper half
    fork
      for (int i = 0; i < 50; i++) begin
        write_txn(rand_addr(0, MEM_DEPTH / 2, 0), {next_rand(), next_rand()},
                  STRB_WIDTH'(next_rand()), next_rand() % 6);
      end
      for (int i = 0; i < 50; i++) begin
        read_txn(rand_addr(MEM_DEPTH / 2, MEM_DEPTH / 2, 0), next_rand() % 6);
      end
    join
    for (int i = 0; i < MEM_DEPTH / 2; i++) begin
      read_txn(i * STRB_WIDTH, 0);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* files.f */
verilog/axil_mem_pkg.sv
verilog/strobe_sram.sv
verilog/axil_wr_ctrl.sv
verilog/axil_rd_ctrl.sv
verilog/axil_data_sram.sv
tb/tb_axil_data_sram.sv
